// File: hw/usb_host_config.svh
`ifndef USB_HOST_CONFIG_SVH
`define USB_HOST_CONFIG_SVH

// Address handed to the device by SET_ADDRESS
`define USB_DEV_ADDR 7'd9

// Frame number carried by the single SOF token
`define USB_SOF_FRAME 11'h123

// Language ID for string descriptor reads (English, US)
`define USB_LANG_EN_US 16'h0409

// wLength of every descriptor read
`define USB_DESC_LEN 16'd64

// Standard request codes
`define USB_REQ_GET_DESC 8'd6
`define USB_REQ_SET_ADDR 8'd5
`define USB_REQ_SET_CONF 8'd9

`endif

// File: hw/usb_host_pkg.sv
package usb_host_pkg;

  // One byte on the packet stream
  typedef logic [7:0] byte_t;

  typedef logic [6:0] dev_addr_t;
  typedef logic [3:0] endp_t;

  // Endpoint over address or the frame number for SOF
  typedef logic [10:0] tok_field_t;

  // 8-byte setup request whose byte 0 sits in bits 7:0 and goes out first
  typedef logic [63:0] setup_t;

  typedef logic [15:0] crc16_t;

  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011
  } pid_e;

  // Enumeration script stages in the order they run
  typedef enum logic [3:0] {
    STAGE_INIT = 4'h0,
    STAGE_DESC = 4'h1,
    STAGE_ENUM = 4'h2,
    STAGE_CONF = 4'h3,
    STAGE_STR0 = 4'h4,
    STAGE_IDLE = 4'hf
  } stage_e;

  // Token CRC5 over the 11-bit field fed LSB first
  function automatic logic [4:0] crc5(input tok_field_t field);
    logic [4:0] crc;
    logic       fb;
    logic [4:0] res;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb  = field[i] ^ crc[4];
      crc = {crc[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
    end
    // The CRC goes out MSB first, so reverse it into the LSB-first token word
    for (int i = 0; i < 5; i++) begin
      res[i] = ~crc[4 - i];
    end
    return res;
  endfunction

  // One byte step of the reflected CRC16 with the final inversion left to the caller
  function automatic crc16_t crc16_byte(input crc16_t crc, input byte_t data);
    crc16_t c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 16'hA001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

// File: hw/packet_tx.sv
`timescale 1ns/1ns

module packet_tx import usb_host_pkg::*; (
  input  logic       clock,
  input  logic       arst_n_i,
  input  logic       pkt_start_i,
  input  pid_e       pkt_pid_i,
  input  tok_field_t pkt_field_i,
  input  setup_t     pkt_payload_i,
  input  logic       pkt_has_payload_i,
  input  logic       tx_ready_i,
  output logic       pkt_done_o,
  output logic       tx_valid_o,
  output logic       tx_last_o,
  output byte_t      tx_data_o
);

  // Part of the packet that the byte on the stream belongs to
  typedef enum logic [1:0] {
    KIND_PID,
    KIND_BODY,
    KIND_CRC_LO,
    KIND_CRC_HI
  } kind_e;

  kind_e      kind_q;
  logic       valid_q;
  logic       last_q;
  logic       done_q;
  logic       is_data_q;
  logic [3:0] body_cnt_q;
  byte_t      data_q;
  setup_t     shift_q;
  crc16_t     crc_q;
  crc16_t     crc_nxt;
  logic       accept;
  logic       start;
  logic       start_is_data;

  assign accept        = valid_q && tx_ready_i;
  assign start         = pkt_start_i && !valid_q;
  // DATA0/DATA1 end in 2'b11, tokens in 2'b01
  assign start_is_data = (pkt_pid_i[1:0] == 2'b11);

  // Fold the body byte being accepted into the running CRC16
  assign crc_nxt = (kind_q == KIND_BODY) ? crc16_byte(crc_q, data_q) : crc_q;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      done_q     <= 1'b0;
      is_data_q  <= 1'b0;
      kind_q     <= KIND_PID;
      body_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        valid_q   <= 1'b1;
        last_q    <= 1'b0;
        is_data_q <= start_is_data;
        kind_q    <= KIND_PID;
        if (start_is_data) begin
          body_cnt_q <= pkt_has_payload_i ? 4'd8 : 4'd0;
        end else begin
          body_cnt_q <= 4'd2;
        end
      end else if (accept) begin
        if (last_q) begin
          valid_q <= 1'b0;
          last_q  <= 1'b0;
          done_q  <= 1'b1;
        end else if (body_cnt_q != '0) begin
          kind_q     <= KIND_BODY;
          body_cnt_q <= body_cnt_q - 4'd1;
          // Tokens end on their second field byte
          last_q     <= (body_cnt_q == 4'd1) && !is_data_q;
        end else if (kind_q != KIND_CRC_LO) begin
          kind_q <= KIND_CRC_LO;
        end else begin
          kind_q <= KIND_CRC_HI;
          last_q <= 1'b1;
        end
      end
    end
  end

  // Byte datapath
  always_ff @(posedge clock) begin
    if (start) begin
      data_q <= {~pkt_pid_i, pkt_pid_i};
      crc_q  <= 16'hFFFF;
      if (start_is_data) begin
        shift_q <= pkt_payload_i;
      end else begin
        shift_q <= {48'd0, crc5(pkt_field_i), pkt_field_i};
      end
    end else if (accept && !last_q) begin
      crc_q <= crc_nxt;
      if (body_cnt_q != '0) begin
        data_q  <= shift_q[7:0];
        shift_q <= shift_q >> 8;
      end else if (kind_q != KIND_CRC_LO) begin
        data_q <= ~crc_nxt[7:0];
      end else begin
        data_q <= ~crc_q[15:8];
      end
    end
  end

  assign tx_valid_o = valid_q;
  assign tx_last_o  = last_q;
  assign tx_data_o  = data_q;
  assign pkt_done_o = done_q;

  // Byte and end marker hold while the sink stalls
  a_hold_under_stall: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    valid_q && !tx_ready_i |=> valid_q && $stable(data_q) && $stable(last_q)
  );

  a_last_with_valid: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    last_q |-> valid_q
  );

endmodule

// File: hw/control_xfer.sv
`timescale 1ns/1ns

`include "usb_host_config.svh"

module control_xfer import usb_host_pkg::*; (
  input  logic       clock,
  input  logic       arst_n_i,
  input  logic       xfer_start_i,
  input  logic       sof_start_i,
  input  dev_addr_t  xfer_addr_i,
  input  setup_t     xfer_setup_i,
  input  logic       ack_i,
  input  logic       pkt_done_i,
  output logic       xfer_done_o,
  output logic       pkt_start_o,
  output pid_e       pkt_pid_o,
  output tok_field_t pkt_field_o,
  output setup_t     pkt_payload_o,
  output logic       pkt_has_payload_o
);

  localparam endp_t EP0 = 4'h0;

  typedef enum logic [2:0] {
    X_IDLE,
    X_SETUP_TOK,
    X_SETUP_DATA,
    X_SETUP_ACK,
    X_STAT_TOK,
    X_STAT_DATA,
    X_STAT_ACK,
    X_SOF
  } xfer_state_e;

  xfer_state_e state_q;
  logic        start_q;
  logic        done_q;
  logic        has_payload_q;
  pid_e        pid_q;
  tok_field_t  field_q;
  setup_t      setup_q;
  logic        dir_in;

  // A device-to-host request takes a host-to-device status stage
  assign dir_in = setup_q[7];

  always_ff @(posedge clock) begin
    if (state_q == X_IDLE && xfer_start_i) begin
      setup_q <= xfer_setup_i;
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= X_IDLE;
      start_q       <= 1'b0;
      done_q        <= 1'b0;
      has_payload_q <= 1'b0;
      pid_q         <= PID_OUT;
      field_q       <= '0;
    end else begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        X_IDLE: begin
          if (xfer_start_i) begin
            start_q       <= 1'b1;
            pid_q         <= PID_SETUP;
            field_q       <= {EP0, xfer_addr_i};
            has_payload_q <= 1'b0;
            state_q       <= X_SETUP_TOK;
          end else if (sof_start_i) begin
            start_q       <= 1'b1;
            pid_q         <= PID_SOF;
            field_q       <= `USB_SOF_FRAME;
            has_payload_q <= 1'b0;
            state_q       <= X_SOF;
          end
        end
        X_SETUP_TOK: begin
          if (pkt_done_i) begin
            start_q       <= 1'b1;
            pid_q         <= PID_DATA0;
            has_payload_q <= 1'b1;
            state_q       <= X_SETUP_DATA;
          end
        end
        X_SETUP_DATA: begin
          if (pkt_done_i) begin
            state_q <= X_SETUP_ACK;
          end
        end
        X_SETUP_ACK: begin
          if (ack_i) begin
            start_q       <= 1'b1;
            pid_q         <= dir_in ? PID_OUT : PID_IN;
            has_payload_q <= 1'b0;
            state_q       <= X_STAT_TOK;
          end
        end
        X_STAT_TOK: begin
          if (pkt_done_i) begin
            if (dir_in) begin
              // Zero-length DATA1 closes a read
              start_q <= 1'b1;
              pid_q   <= PID_DATA1;
              state_q <= X_STAT_DATA;
            end else begin
              state_q <= X_STAT_ACK;
            end
          end
        end
        X_STAT_DATA: begin
          if (pkt_done_i) begin
            state_q <= X_STAT_ACK;
          end
        end
        X_STAT_ACK: begin
          if (ack_i) begin
            done_q  <= 1'b1;
            state_q <= X_IDLE;
          end
        end
        X_SOF: begin
          if (pkt_done_i) begin
            done_q  <= 1'b1;
            state_q <= X_IDLE;
          end
        end
        default: state_q <= X_IDLE;
      endcase
    end
  end

  assign xfer_done_o       = done_q;
  assign pkt_start_o       = start_q;
  assign pkt_pid_o         = pid_q;
  assign pkt_field_o       = field_q;
  assign pkt_payload_o     = setup_q;
  assign pkt_has_payload_o = has_payload_q;

  // Next start waits until the serializer finishes the packet in flight
  a_one_packet: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    start_q |=> (!start_q throughout pkt_done_i [->1])
  );

endmodule

// File: hw/enum_sequencer.sv
`timescale 1ns/1ns

`include "usb_host_config.svh"

module enum_sequencer import usb_host_pkg::*; (
  input  logic      clock,
  input  logic      arst_n_i,
  input  logic      enable_i,
  input  logic      enum_start_i,
  input  logic      xfer_done_i,
  output logic      xfer_start_o,
  output logic      sof_start_o,
  output dev_addr_t xfer_addr_o,
  output setup_t    xfer_setup_o,
  output stage_e    stage_o,
  output logic      done_o
);

  // bmRequestType for standard device requests
  localparam logic [7:0] RT_DEV_IN  = 8'h80;
  localparam logic [7:0] RT_DEV_OUT = 8'h00;

  stage_e stage_q;
  logic   start_q;
  logic   sof_q;
  logic   sof_sent_q;
  logic   done_q;

  function automatic setup_t make_setup(
    input logic [7:0]  rtype,
    input logic [7:0]  req,
    input logic [15:0] value,
    input logic [15:0] index,
    input logic [15:0] length
  );
    return {length, index, value, req, rtype};
  endfunction

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage_q    <= STAGE_INIT;
      start_q    <= 1'b0;
      sof_q      <= 1'b0;
      sof_sent_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      sof_q   <= 1'b0;
      case (stage_q)
        STAGE_INIT: begin
          if (enable_i && enum_start_i) begin
            stage_q <= STAGE_DESC;
            start_q <= 1'b1;
          end
        end
        STAGE_DESC: begin
          if (xfer_done_i) begin
            stage_q <= STAGE_ENUM;
            start_q <= 1'b1;
          end
        end
        STAGE_ENUM: begin
          // SET_ADDRESS first and then one SOF before moving on
          if (xfer_done_i && sof_sent_q) begin
            stage_q <= STAGE_CONF;
            start_q <= 1'b1;
          end else if (xfer_done_i) begin
            sof_q      <= 1'b1;
            sof_sent_q <= 1'b1;
          end
        end
        STAGE_CONF: begin
          if (xfer_done_i) begin
            stage_q <= STAGE_STR0;
            start_q <= 1'b1;
          end
        end
        STAGE_STR0: begin
          if (xfer_done_i) begin
            stage_q <= STAGE_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Request for the current stage stays stable while its transfer runs
  always_comb begin
    xfer_addr_o  = '0;
    xfer_setup_o = '0;
    case (stage_q)
      STAGE_DESC: begin
        xfer_setup_o = make_setup(RT_DEV_IN, `USB_REQ_GET_DESC, 16'h0100, 16'h0000,
                                  `USB_DESC_LEN);
      end
      STAGE_ENUM: begin
        xfer_setup_o = make_setup(RT_DEV_OUT, `USB_REQ_SET_ADDR, {9'd0, `USB_DEV_ADDR},
                                  16'h0000, 16'h0000);
      end
      STAGE_CONF: begin
        xfer_addr_o  = `USB_DEV_ADDR;
        xfer_setup_o = make_setup(RT_DEV_OUT, `USB_REQ_SET_CONF, 16'h0001, 16'h0000,
                                  16'h0000);
      end
      STAGE_STR0: begin
        // Serial number string at index 3
        xfer_addr_o  = `USB_DEV_ADDR;
        xfer_setup_o = make_setup(RT_DEV_IN, `USB_REQ_GET_DESC, 16'h0303, `USB_LANG_EN_US,
                                  `USB_DESC_LEN);
      end
      default: ;
    endcase
  end

  assign xfer_start_o = start_q;
  assign sof_start_o  = sof_q;
  assign stage_o      = stage_q;
  assign done_o       = done_q;

  a_stage_forward: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    (stage_q != $past(stage_q)) |-> (stage_q > $past(stage_q))
  );

endmodule

// File: hw/usb_ctrl_host.sv
`timescale 1ns/1ns

module usb_ctrl_host import usb_host_pkg::*; (
  input  logic   clock,
  input  logic   arst_n_i,
  input  logic   enable_i,
  input  logic   enum_start_i,
  input  logic   ack_i,
  input  logic   tx_ready_i,
  output logic   tx_valid_o,
  output logic   tx_last_o,
  output byte_t  tx_data_o,
  output stage_e stage_o,
  output logic   done_o
);

  // Sequencer to transfer engine
  logic       xfer_start;
  logic       sof_start;
  logic       xfer_done;
  dev_addr_t  xfer_addr;
  setup_t     xfer_setup;

  // Transfer engine to serializer
  logic       pkt_start;
  logic       pkt_done;
  pid_e       pkt_pid;
  tok_field_t pkt_field;
  setup_t     pkt_payload;
  logic       pkt_has_payload;

  enum_sequencer enum_sequencer_i (
    .clock        (clock),
    .arst_n_i     (arst_n_i),
    .enable_i     (enable_i),
    .enum_start_i (enum_start_i),
    .xfer_done_i  (xfer_done),
    .xfer_start_o (xfer_start),
    .sof_start_o  (sof_start),
    .xfer_addr_o  (xfer_addr),
    .xfer_setup_o (xfer_setup),
    .stage_o      (stage_o),
    .done_o       (done_o)
  );

  control_xfer control_xfer_i (
    .clock             (clock),
    .arst_n_i          (arst_n_i),
    .xfer_start_i      (xfer_start),
    .sof_start_i       (sof_start),
    .xfer_addr_i       (xfer_addr),
    .xfer_setup_i      (xfer_setup),
    .ack_i             (ack_i),
    .pkt_done_i        (pkt_done),
    .xfer_done_o       (xfer_done),
    .pkt_start_o       (pkt_start),
    .pkt_pid_o         (pkt_pid),
    .pkt_field_o       (pkt_field),
    .pkt_payload_o     (pkt_payload),
    .pkt_has_payload_o (pkt_has_payload)
  );

  packet_tx packet_tx_i (
    .clock             (clock),
    .arst_n_i          (arst_n_i),
    .pkt_start_i       (pkt_start),
    .pkt_pid_i         (pkt_pid),
    .pkt_field_i       (pkt_field),
    .pkt_payload_i     (pkt_payload),
    .pkt_has_payload_i (pkt_has_payload),
    .tx_ready_i        (tx_ready_i),
    .pkt_done_o        (pkt_done),
    .tx_valid_o        (tx_valid_o),
    .tx_last_o         (tx_last_o),
    .tx_data_o         (tx_data_o)
  );

endmodule

// File: tb/usb_ctrl_host_tb.sv
`timescale 1ns/1ns

`include "usb_host_config.svh"

module usb_ctrl_host_tb import usb_host_pkg::*; ();

  localparam logic [31:0] SEED = 32'h731dda9f;

  logic   clock;
  logic   arst_n_i;
  logic   enable_i;
  logic   enum_start_i;
  logic   ack_i;
  logic   tx_ready_i;
  logic   tx_valid_o;
  logic   tx_last_o;
  byte_t  tx_data_o;
  stage_e stage_o;
  logic   done_o;

  // Expected stream with one entry per byte
  byte_t exp_data[$];
  bit    exp_last[$];
  bit    exp_ack[$];

  int    errors = 0;
  int    idx = 0;
  int    n_acks = 0;
  int    ack_cnt = 0;
  int    limit_cycles = 0;
  bit    ack_wait = 1'b0;
  bit    stall_q = 1'b0;
  bit    model_ready = 1'b0;
  byte_t held_data;
  logic  held_last;

  usb_ctrl_host usb_ctrl_host_i (
    .clock        (clock),
    .arst_n_i     (arst_n_i),
    .enable_i     (enable_i),
    .enum_start_i (enum_start_i),
    .ack_i        (ack_i),
    .tx_ready_i   (tx_ready_i),
    .tx_valid_o   (tx_valid_o),
    .tx_last_o    (tx_last_o),
    .tx_data_o    (tx_data_o),
    .stage_o      (stage_o),
    .done_o       (done_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  task automatic push_byte(input byte_t b, input bit last, input bit ack);
    exp_data.push_back(b);
    exp_last.push_back(last);
    exp_ack.push_back(ack);
    if (ack) begin
      n_acks++;
    end
  endtask

  // Token is the PID byte and then the CRC5 word sent LSB first
  task automatic add_token(input pid_e pid, input tok_field_t field, input bit needs_ack);
    logic [15:0] word;
    word = {crc5(field), field};
    push_byte({~pid, pid}, 1'b0, 1'b0);
    push_byte(word[7:0], 1'b0, 1'b0);
    push_byte(word[15:8], 1'b1, needs_ack);
  endtask

  task automatic add_data(input pid_e pid, input setup_t payload, input int nbytes,
                          input bit needs_ack);
    crc16_t crc;
    byte_t  b;
    crc = 16'hFFFF;
    push_byte({~pid, pid}, 1'b0, 1'b0);
    for (int i = 0; i < nbytes; i++) begin
      b   = payload[8*i +: 8];
      crc = crc16_byte(crc, b);
      push_byte(b, 1'b0, 1'b0);
    end
    crc = ~crc;
    push_byte(crc[7:0], 1'b0, 1'b0);
    push_byte(crc[15:8], 1'b1, needs_ack);
  endtask

  // Read requests close with OUT and an empty DATA1 and other requests with IN
  task automatic add_control(input dev_addr_t addr, input setup_t setup);
    tok_field_t field;
    field = {4'h0, addr};
    add_token(PID_SETUP, field, 1'b0);
    add_data(PID_DATA0, setup, 8, 1'b1);
    if (setup[7]) begin
      add_token(PID_OUT, field, 1'b0);
      add_data(PID_DATA1, setup, 0, 1'b1);
    end else begin
      add_token(PID_IN, field, 1'b1);
    end
  endtask

  task automatic build_script();
    add_control(7'd0, {`USB_DESC_LEN, 16'h0000, 16'h0100, `USB_REQ_GET_DESC, 8'h80});
    add_control(7'd0, {16'h0000, 16'h0000, {9'd0, `USB_DEV_ADDR}, `USB_REQ_SET_ADDR,
                       8'h00});
    add_token(PID_SOF, `USB_SOF_FRAME, 1'b0);
    add_control(`USB_DEV_ADDR, {16'h0000, 16'h0000, 16'h0001, `USB_REQ_SET_CONF, 8'h00});
    add_control(`USB_DEV_ADDR, {`USB_DESC_LEN, `USB_LANG_EN_US, 16'h0303,
                                `USB_REQ_GET_DESC, 8'h80});
  endtask

  function automatic stage_e expected_stage(input int k);
    case (k)
      0:       return STAGE_DESC;
      1:       return STAGE_ENUM;
      2:       return STAGE_CONF;
      3:       return STAGE_STR0;
      default: return STAGE_IDLE;
    endcase
  endfunction

  task automatic check_idle();
    check_value("tx_valid_o", tx_valid_o, 1'b0);
    check_value("tx_last_o", tx_last_o, 1'b0);
    check_value("done_o", done_o, 1'b0);
    check_value("stage_o", stage_o, STAGE_INIT);
  endtask

  task automatic accept_byte();
    if (idx >= exp_data.size()) begin
      note_failure("byte accepted after the end of the script");
    end else begin
      check_value("tx_data_o", tx_data_o, exp_data[idx]);
      check_value("tx_last_o", tx_last_o, exp_last[idx]);
      if (exp_ack[idx]) begin
        ack_wait = 1'b1;
        ack_cnt  = 2 + ($urandom % 9);
      end
      idx++;
    end
  endtask

  // One clock edge of the sink and the device side
  task automatic step_stream();
    if (!arst_n_i) begin
      stall_q  = 1'b0;
      ack_wait = 1'b0;
      ack_cnt  = 0;
      ack_i   <= 1'b0;
    end else begin
      if (stall_q) begin
        check_value("tx_valid_o", tx_valid_o, 1'b1);
        check_value("tx_data_o", tx_data_o, held_data);
        check_value("tx_last_o", tx_last_o, held_last);
      end
      if (tx_valid_o && ack_wait) begin
        note_failure("byte sent while the phase waits for an acknowledge");
      end
      ack_i <= 1'b0;
      if (ack_cnt != 0) begin
        ack_cnt--;
        if (ack_cnt == 0) begin
          ack_i <= 1'b1;
        end
      end else if (ack_wait) begin
        // The DUT samples the pulse at this edge
        ack_wait = 1'b0;
      end else if (tx_valid_o && ($urandom % 16 == 0)) begin
        // Stray pulse while a packet streams
        ack_i <= 1'b1;
      end
      if (tx_valid_o && tx_ready_i) begin
        accept_byte();
      end
      stall_q   = tx_valid_o && !tx_ready_i;
      held_data = tx_data_o;
      held_last = tx_last_o;
    end
    tx_ready_i <= ($urandom % 10) < 7;
  endtask

  initial begin : stream_stimulus
    tx_ready_i = 1'b0;
    ack_i      = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(posedge clock);
      step_stream();
    end
  end

  initial begin : main_sequence
    stage_e prev_stage;
    int     stage_idx;
    arst_n_i     = 1'b0;
    enable_i     = 1'b0;
    enum_start_i = 1'b0;
    build_script();
    limit_cycles = 200 + exp_data.size() * 40 + n_acks * 12;
    model_ready  = 1'b1;

    // First edge applies the reset
    @(posedge clock);
    repeat (15) begin
      @(posedge clock);
      check_idle();
    end
    arst_n_i <= 1'b1;

    // Start request while disabled must be ignored
    @(posedge clock);
    enum_start_i <= 1'b1;
    @(posedge clock);
    enum_start_i <= 1'b0;
    repeat (8) begin
      @(posedge clock);
      check_idle();
    end

    enable_i <= 1'b1;
    @(posedge clock);
    enum_start_i <= 1'b1;
    @(posedge clock);
    enum_start_i <= 1'b0;

    prev_stage = STAGE_INIT;
    stage_idx  = 0;
    while (done_o !== 1'b1) begin
      @(posedge clock);
      if (stage_o !== prev_stage) begin
        check_value("stage_o", stage_o, expected_stage(stage_idx));
        stage_idx++;
        prev_stage = stage_o;
      end
    end
    if (stage_idx != 5) begin
      note_failure("stage_o did not step through all five stages");
    end
    check_value("bytes accepted", idx, exp_data.size());
    if (ack_wait) begin
      note_failure("done_o rose before the final acknowledge");
    end

    // The stream process flags any extra byte during this quiet period
    repeat (20) @(posedge clock);
    check_value("tx_valid_o", tx_valid_o, 1'b0);
    check_value("stage_o", stage_o, STAGE_IDLE);

    $display("Bytes checked: %0d of %0d, errors: %0d", idx, exp_data.size(), errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (model_ready);
    repeat (limit_cycles) @(posedge clock);
    $display("Timeout: the enumeration script did not finish within %0d cycles",
             limit_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+hw
hw/usb_host_pkg.sv
hw/packet_tx.sv
hw/control_xfer.sv
hw/enum_sequencer.sv
hw/usb_ctrl_host.sv
tb/usb_ctrl_host_tb.sv

// File: Bender.yml
package:
  name: usb_ctrl_host

sources:
  - include_dirs:
      - hw
    files:
      - hw/usb_host_pkg.sv
      - hw/packet_tx.sv
      - hw/control_xfer.sv
      - hw/enum_sequencer.sv
      - hw/usb_ctrl_host.sv
      - target: test
        files:
          - tb/usb_ctrl_host_tb.sv
